/* files.f */
rtl/cclk_pkg.sv
rtl/cclk_pattern_gen.sv
rtl/cclk_pattern_fifo.sv
rtl/cclk_word_out.sv
rtl/cclk_gen_top.sv
dv/cclk_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the cclk testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 -f files.f --top-module cclk_tb -o cclk_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

out=$(./obj_dir/cclk_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qxF '>>> PASS'; then
   exit 0
fi
exit 1

/* dv/cclk_tb.sv */
module cclk_tb;

   import cclk_pkg::*;

   localparam int DISCARD    = FIFO_DEPTH + 4;   // Words flushed after a setting change
   localparam int CHECKED    = 24;               // Pattern words checked per test
   localparam int WAIT_LIMIT = 64;               // Cycles allowed per word

   logic                  cclk_div;
   logic                  reset;
   logic [DIVCFG_W-1:0]   divcfg;
   logic                  load;
   logic [PAT_W-1:0]      ser_word;
   logic                  word_valid;
   logic [EDGE_CNT_W-1:0] edge_count;

   // Reference model state
   logic [DIVCFG_W-1:0]   m_sync0;               // Setting after one edge
   logic [DIVCFG_W-1:0]   m_sync1;               // After two edges
   cclk_mode_e            m_mode;                // Mode of words pushed now
   logic                  m_phase;               // Divide by 8, 1 -> zeros next
   logic [PAT_W-1:0]      m_fifo [$];            // Words waiting for a load
   logic [PAT_W-1:0]      m_word;
   logic                  m_valid;
   logic                  m_last;                // Last bit sent
   logic [EDGE_CNT_W-1:0] m_edges;
   logic                  filled;                // FIFO held a word since reset

   int errors;
   int checks;
   int tests;
   bit aborted;                                  // Set by a timeout

   cclk_gen_top dut0 (
      .cclk_div   (cclk_div),
      .reset      (reset),
      .divcfg     (divcfg),
      .load       (load),
      .ser_word   (ser_word),
      .word_valid (word_valid),
      .edge_count (edge_count)
   );

   initial begin
      cclk_div = 1'b0;
      forever #50 cclk_div = ~cclk_div;          // Period 100
   end

   function automatic cclk_mode_e mode_of(input logic [DIVCFG_W-1:0] code);
      case (code)
         4'd0:    return MODE_OFF;
         4'd7:    return MODE_DIV1;
         4'd6:    return MODE_DIV2;
         4'd5:    return MODE_DIV4;
         default: return MODE_DIV8;
      endcase
   endfunction

   function automatic logic [PAT_W-1:0] word_of(input cclk_mode_e m, input logic ph);
      case (m)
         MODE_OFF:  return 8'h00;
         MODE_DIV1: return 8'hAA;
         MODE_DIV2: return 8'hCC;
         MODE_DIV4: return 8'hF0;
         default:   return ph ? 8'h00 : 8'hFF;
      endcase
   endfunction

   // Rises over prev bit then bits 0..7
   function automatic int rises_in(input logic prev, input logic [PAT_W-1:0] w);
      int   n;
      logic b;
      n = 0;
      b = prev;
      for (int i = 0; i < PAT_W; i++) begin
         if (!b && w[i])
            n++;
         b = w[i];
      end
      return n;
   endfunction

   // Codes 1..4 and 8..15
   function automatic logic [DIVCFG_W-1:0] div8_code();
      int r;
      r = $urandom_range(11, 0);
      return (r < 4) ? DIVCFG_W'(r + 1) : DIVCFG_W'(r + 4);
   endfunction

   // One clock edge of the model, inputs already driven
   task automatic model_edge();
      bit               push_now;
      logic [PAT_W-1:0] in_word;
      logic [PAT_W-1:0] out_word;
      push_now = (m_fifo.size() != FIFO_DEPTH);
      in_word  = word_of(m_mode, m_phase);
      if (load) begin
         out_word = (m_fifo.size() == 0) ? 8'h00 : m_fifo[0];   // Underflow sends zeros
         m_valid  = (m_fifo.size() != 0);
         m_edges  = m_edges + EDGE_CNT_W'(rises_in(m_last, out_word));
         m_last   = out_word[PAT_W-1];
         m_word   = out_word;
         if (m_fifo.size() != 0)
            void'(m_fifo.pop_front());
      end else begin
         m_valid = 1'b0;                          // Word holds
      end
      if (push_now)
         m_fifo.push_back(in_word);
      if (m_mode != MODE_DIV8)
         m_phase = 1'b0;
      else if (push_now)
         m_phase = ~m_phase;
      m_mode  = mode_of(m_sync1);                 // Third edge after the change
      m_sync1 = m_sync0;
      m_sync0 = divcfg;
   endtask

   task automatic compare_outputs(input bit ld, input bit was_filled);
      checks++;
      assert (word_valid === m_valid) else begin
         $display("FAIL word_valid expected %h got %h", m_valid, word_valid);
         errors++;
      end
      assert (ser_word === m_word) else begin
         $display("FAIL ser_word expected %h got %h", m_word, ser_word);
         errors++;
      end
      assert (edge_count === m_edges) else begin
         $display("FAIL edge_count expected %h got %h", m_edges, edge_count);
         errors++;
      end
      assert (!(ld && was_filled && !word_valid)) else begin
         $display("Underflow: a load found no word after the FIFO had filled");
         errors++;
      end
   endtask

   // Drive on the falling edge, check on the next one
   task automatic tick(input bit ld);
      bit was_filled;
      load       = ld;
      was_filled = filled;
      model_edge();
      @(posedge cclk_div);
      @(negedge cclk_div);
      compare_outputs(ld, was_filled);
      if (m_fifo.size() != 0)
         filled = 1'b1;
   endtask

   task automatic wait_word(input int pct, output logic [PAT_W-1:0] w);
      w = '0;
      for (int t = 0; t < WAIT_LIMIT; t++) begin
         tick($urandom_range(99, 0) < pct);
         if (word_valid) begin
            w = ser_word;
            return;
         end
      end
      $display("Timeout: no word_valid within %0d cycles", WAIT_LIMIT);
      errors++;
      aborted = 1'b1;
   endtask

   task automatic run_test(input string label, input logic [DIVCFG_W-1:0] code,
                           input int pct);
      cclk_mode_e            m;
      logic [PAT_W-1:0]      w;
      logic [PAT_W-1:0]      prev_w;
      logic [EDGE_CNT_W-1:0] edge_ref;
      int                    errs_before;
      if (aborted)
         return;
      errs_before = errors;
      m           = mode_of(code);
      divcfg      = code;
      prev_w      = '0;
      edge_ref    = '0;
      for (int n = 0; n < DISCARD + CHECKED; n++) begin
         wait_word(pct, w);
         if (aborted)
            break;
         if (n >= DISCARD && m == MODE_DIV8) begin
            assert ((n == DISCARD) ? (w == 8'hFF || w == 8'h00) : (w == ~prev_w)) else begin
               $display("FAIL ser_word expected %h got %h", ~prev_w, w);
               errors++;
            end
         end else if (n >= DISCARD) begin
            assert (w == word_of(m, 1'b0)) else begin
               $display("FAIL ser_word expected %h got %h", word_of(m, 1'b0), w);
               errors++;
            end
         end
         if (n == DISCARD)
            edge_ref = m_edges;                   // Clock off adds no edges
         if (n > DISCARD && m == MODE_OFF) begin
            assert (edge_count == edge_ref) else begin
               $display("FAIL edge_count expected %h got %h", edge_ref, edge_count);
               errors++;
            end
         end
         prev_w = w;
      end
      tests++;
      $display("test %-12s code %2d mode %-9s load %3d%%: %s", label, code, m.name(), pct,
               (errors == errs_before) ? "ok" : "failed");
   endtask

   initial begin
      void'($urandom(77));
      errors  = 0;
      checks  = 0;
      tests   = 0;
      aborted = 1'b0;
      reset   = 1'b1;
      load    = 1'b0;
      divcfg  = '0;
      m_sync0 = '0;
      m_sync1 = '0;
      m_mode  = MODE_OFF;
      m_phase = 1'b0;
      m_word  = 8'h00;
      m_valid = 1'b0;
      m_last  = 1'b0;
      m_edges = '0;
      filled  = 1'b0;
      repeat (3) @(posedge cclk_div);
      @(negedge cclk_div);
      reset = 1'b0;
      repeat (8) tick(1'b0);                      // FIFO fills before loads start
      run_test("off", 4'd0, 100);
      run_test("div1", 4'd7, 100);
      run_test("div2", 4'd6, 100);
      run_test("div4", 4'd5, 100);
      run_test("div8", div8_code(), 100);
      run_test("backpressure", div8_code(), 50);
      for (int i = 0; i < 6; i++)
         run_test("random", DIVCFG_W'($urandom_range(15, 0)), 60);
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

/* rtl/cclk_gen_top.sv */
module cclk_gen_top (
   input  logic                            cclk_div,
   input  logic                            reset,
   input  logic [cclk_pkg::DIVCFG_W-1:0]    divcfg,
   input  logic                            load,
   output logic [cclk_pkg::PAT_W-1:0]       ser_word,
   output logic                            word_valid,
   output logic [cclk_pkg::EDGE_CNT_W-1:0]  edge_count
);

   import cclk_pkg::*;

   logic             push;                        // Producer to FIFO
   logic [PAT_W-1:0] push_data;
   logic             full;
   logic             pop;                         // FIFO to consumer
   logic [PAT_W-1:0] pop_data;
   logic             empty;

   cclk_pattern_gen gen0 (
      .cclk_div   (cclk_div),
      .reset      (reset),
      .divcfg     (divcfg),
      .full       (full),
      .push       (push),
      .push_data  (push_data)
   );

   cclk_pattern_fifo fifo0 (
      .cclk_div   (cclk_div),
      .reset      (reset),
      .push       (push),
      .push_data  (push_data),
      .pop        (pop),
      .pop_data   (pop_data),
      .full       (full),
      .empty      (empty)
   );

   cclk_word_out out0 (
      .cclk_div   (cclk_div),
      .reset      (reset),
      .load       (load),
      .empty      (empty),
      .pop_data   (pop_data),
      .pop        (pop),
      .ser_word   (ser_word),
      .word_valid (word_valid),
      .edge_count (edge_count)
   );

endmodule

/* rtl/cclk_word_out.sv */
module cclk_word_out (
   input  logic                            cclk_div,
   input  logic                            reset,
   input  logic                            load,       // Serializer word strobe
   input  logic                            empty,
   input  logic [cclk_pkg::PAT_W-1:0]       pop_data,
   output logic                            pop,
   output logic [cclk_pkg::PAT_W-1:0]       ser_word,   // To serializer parallel port
   output logic                            word_valid,
   output logic [cclk_pkg::EDGE_CNT_W-1:0]  edge_count
);

   import cclk_pkg::*;

   logic [PAT_W-1:0] next_word;                   // Word going out on this load
   logic [PAT_W:0]   stream;                      // Last bit then bits 0..7
   logic [3:0]       rise_cnt;                    // Up to 4 rises in 9 bits
   logic             last_bit;                    // Bit 7 of the previous word

   // Pop only a word that is there
   assign pop = load & ~empty;

   // Underflow sends the clock low
   assign next_word = empty ? PAT_OFF : pop_data;
   assign stream    = {next_word, last_bit};

   // Count 0 -> 1 steps, bit 0 is the oldest
   always_comb begin
      rise_cnt = '0;
      for (int i = 0; i < PAT_W; i++) begin
         if (!stream[i] && stream[i+1])
            rise_cnt = rise_cnt + 1'b1;
      end
   end

   // Word register and valid strobe
   always_ff @(posedge cclk_div) begin
      if (reset) begin
         ser_word   <= PAT_OFF;
         word_valid <= 1'b0;
         last_bit   <= 1'b0;
      end else if (load) begin
         ser_word   <= next_word;
         word_valid <= ~empty;                    // Low on underflow
         last_bit   <= next_word[PAT_W-1];
      end else begin
         word_valid <= 1'b0;                      // ser_word holds
      end
   end

   // Running edge count, wraps at 16 bits
   always_ff @(posedge cclk_div) begin
      if (reset)
         edge_count <= '0;
      else if (load)
         edge_count <= edge_count + EDGE_CNT_W'(rise_cnt);
   end

   // Valid only follows a load strobe
   a_valid_after_load : assert property (
      @(posedge cclk_div) disable iff (reset) word_valid |-> $past(load)
   ) else $error("cclk_word_out: word_valid without load");

endmodule

/* rtl/cclk_pattern_fifo.sv */
module cclk_pattern_fifo (
   input  logic                      cclk_div,
   input  logic                      reset,
   input  logic                      push,
   input  logic [cclk_pkg::PAT_W-1:0] push_data,
   input  logic                      pop,
   output logic [cclk_pkg::PAT_W-1:0] pop_data,   // Head entry, no register
   output logic                      full,
   output logic                      empty
);

   import cclk_pkg::*;

   logic [PAT_W-1:0]   mem [FIFO_DEPTH];          // Pattern storage
   logic [FIFO_AW-1:0] wr_ptr;                    // Next free slot
   logic [FIFO_AW-1:0] rd_ptr;                    // Head slot
   logic [FIFO_AW:0]   count;                     // Occupancy, one extra bit for full

   // Storage write, payload only
   always_ff @(posedge cclk_div) begin
      if (push)
         mem[wr_ptr] <= push_data;
   end

   // Pointers wrap naturally at depth 4
   always_ff @(posedge cclk_div) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // Push and pop together leave count alone
   always_ff @(posedge cclk_div) begin
      if (reset)
         count <= '0;
      else begin
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign pop_data = mem[rd_ptr];                 // Valid as soon as written
   assign full     = (count == FIFO_DEPTH);
   assign empty    = (count == '0);

   // Producer holds off while full
   a_no_push_full : assert property (
      @(posedge cclk_div) disable iff (reset) full |-> !push
   ) else $error("cclk_pattern_fifo: push while full");

   // Consumer only pops a present word
   a_no_pop_empty : assert property (
      @(posedge cclk_div) disable iff (reset) empty |-> !pop
   ) else $error("cclk_pattern_fifo: pop while empty");

   a_count_range : assert property (
      @(posedge cclk_div) disable iff (reset) count <= FIFO_DEPTH
   ) else $error("cclk_pattern_fifo: count %0d over depth", count);

endmodule

/* rtl/cclk_pattern_gen.sv */
module cclk_pattern_gen (
   input  logic                         cclk_div,
   input  logic                         reset,
   input  logic [cclk_pkg::DIVCFG_W-1:0] divcfg,     // Async to cclk_div
   input  logic                         full,
   output logic                         push,
   output logic [cclk_pkg::PAT_W-1:0]    push_data
);

   import cclk_pkg::*;

   logic [DIVCFG_W-1:0] div_sync0;                // First synchronizer stage
   logic [DIVCFG_W-1:0] div_sync1;                // Second stage, safe to decode
   cclk_mode_e          mode_dec;                 // Decode of synchronized code
   cclk_mode_e          mode;                     // Mode used for pushed words
   logic                div8_phase;               // 0 -> all ones word next

   // Two flop synchronizer for the setting
   always_ff @(posedge cclk_div) begin
      if (reset) begin
         div_sync0 <= '0;
         div_sync1 <= '0;
      end else begin
         div_sync0 <= divcfg;
         div_sync1 <= div_sync0;
      end
   end

   // Code to mode, off only for code 0
   always_comb begin
      case (div_sync1)
         DIVCFG_OFF:  mode_dec = MODE_OFF;
         DIVCFG_DIV1: mode_dec = MODE_DIV1;
         DIVCFG_DIV2: mode_dec = MODE_DIV2;
         DIVCFG_DIV4: mode_dec = MODE_DIV4;
         default:     mode_dec = MODE_DIV8;       // Slowest clock
      endcase
   end

   // Third edge after a setting change
   always_ff @(posedge cclk_div) begin
      if (reset)
         mode <= MODE_OFF;
      else
         mode <= mode_dec;
   end

   // Divide by 8 phase, advances on pushes only so stalls keep it
   always_ff @(posedge cclk_div) begin
      if (reset)
         div8_phase <= 1'b0;
      else if (mode != MODE_DIV8)
         div8_phase <= 1'b0;                      // Entry starts with ones
      else if (push)
         div8_phase <= ~div8_phase;
   end

   // One word per cycle while there is room
   assign push = ~full;

   always_comb begin
      case (mode)
         MODE_OFF:  push_data = PAT_OFF;
         MODE_DIV1: push_data = PAT_DIV1;
         MODE_DIV2: push_data = PAT_DIV2;
         MODE_DIV4: push_data = PAT_DIV4;
         default:   push_data = div8_phase ? PAT_OFF : {PAT_W{1'b1}};
      endcase
   end

   // Mode register never leaves the enum range
   a_mode_legal : assert property (
      @(posedge cclk_div) disable iff (reset)
      mode inside {MODE_OFF, MODE_DIV1, MODE_DIV2, MODE_DIV4, MODE_DIV8}
   ) else $error("cclk_pattern_gen: illegal mode %0d", mode);

endmodule

/* rtl/cclk_pkg.sv */
package cclk_pkg;

   // Divider setting from the clock config register
   localparam int DIVCFG_W = 4;                   // Settings bits 3:0 only

   localparam logic [DIVCFG_W-1:0] DIVCFG_OFF  = 4'd0;  // Core clock stopped
   localparam logic [DIVCFG_W-1:0] DIVCFG_DIV1 = 4'd7;  // Full rate
   localparam logic [DIVCFG_W-1:0] DIVCFG_DIV2 = 4'd6;  // Half rate
   localparam logic [DIVCFG_W-1:0] DIVCFG_DIV4 = 4'd5;  // Quarter rate
   // Every other code selects divide by 8

   // Serializer parallel word, bit 0 leaves first
   localparam int PAT_W = 8;

   localparam logic [PAT_W-1:0] PAT_OFF  = 8'h00;  // Held low
   localparam logic [PAT_W-1:0] PAT_DIV1 = 8'hAA;  // One bit high, one low
   localparam logic [PAT_W-1:0] PAT_DIV2 = 8'hCC;  // Two high, two low
   localparam logic [PAT_W-1:0] PAT_DIV4 = 8'hF0;  // Four high, four low
   // Divide by 8 alternates an all-ones and an all-zeros word

   // Pattern buffer between producer and serializer loads
   localparam int FIFO_DEPTH = 4;                 // Entries
   localparam int FIFO_AW    = 2;                 // Pointer bits, log2 of depth

   // Rising edge counter on the emitted stream
   localparam int EDGE_CNT_W = 16;                // Free running, wraps

   // Decoded clock mode
   typedef enum logic [2:0] {
      MODE_OFF  = 3'd0,                           // Code 0
      MODE_DIV1 = 3'd1,                           // Code 7
      MODE_DIV2 = 3'd2,                           // Code 6
      MODE_DIV4 = 3'd3,                           // Code 5
      MODE_DIV8 = 3'd4                            // Anything else
   } cclk_mode_e;

endpackage
